//--- core_cfg.svh
`ifndef CORE_CFG_SVH
`define CORE_CFG_SVH

//**********************************************************************
// core sizing, fixed by the RV64 ISA
//**********************************************************************

// register and datapath width
`define CORE_XLEN      64

// architectural integer registers
`define CORE_NUM_REGS  32
`define CORE_REG_AW    5

// base instruction length
`define CORE_INST_W    32

`endif

//--- rv_isa_pkg.sv
`include "core_cfg.svh"

package rv_isa_pkg;

    //**********************************************************************
    // ISA-level word types
    //**********************************************************************

    typedef logic [`CORE_XLEN-1:0]   xlen_t;
    typedef logic [`CORE_REG_AW-1:0] reg_idx_t;
    typedef logic [`CORE_INST_W-1:0] inst_t;

    // major opcodes this core understands, inst[6:0]
    typedef enum logic [6:0] {
        OP     = 7'b0110011,
        OP_IMM = 7'b0010011,
        LUI    = 7'b0110111
    } opcode_e;

    //**********************************************************************
    // ALU operations
    //**********************************************************************

    // PASS_B forwards operand b, used for lui
    typedef enum logic [3:0] {
        ADD    = 4'd0,
        SUB    = 4'd1,
        SLL    = 4'd2,
        SLT    = 4'd3,
        SLTU   = 4'd4,
        XOR    = 4'd5,
        SRL    = 4'd6,
        SRA    = 4'd7,
        OR     = 4'd8,
        AND    = 4'd9,
        PASS_B = 4'd10
    } alu_op_e;

endpackage

//--- core_pipe_pkg.sv
package core_pipe_pkg;

    //**********************************************************************
    // stage to stage bundles
    //**********************************************************************

    // decode to execute
    typedef struct packed {
        rv_isa_pkg::alu_op_e  alu_op;
        rv_isa_pkg::xlen_t    op_a;
        rv_isa_pkg::xlen_t    op_b;
        rv_isa_pkg::reg_idx_t rd;
        logic                 wr_en;
        logic                 illegal;
    } dec_ex_t;

    // execute to writeback
    typedef struct packed {
        rv_isa_pkg::reg_idx_t rd;
        rv_isa_pkg::xlen_t    value;
        logic                 wr_en;
        logic                 illegal;
    } ex_wb_t;

    // what the sink sees on res_o
    typedef struct packed {
        rv_isa_pkg::reg_idx_t rd;
        rv_isa_pkg::xlen_t    value;
        logic                 illegal;
    } result_t;

    // handshake controllers
    typedef enum logic [1:0] {ISS_IDLE, ISS_ACKED, ISS_WAIT_WB} issue_state_e;
    typedef enum logic [1:0] {WB_IDLE, WB_REQ, WB_DROP} wb_state_e;

endpackage

//--- inst_issue.sv
`timescale 1ns/1ps

module inst_issue (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              inst_req_i,
    input  rv_isa_pkg::inst_t inst_i,
    input  logic              wb_busy_i,
    output logic              inst_ack_o,
    output rv_isa_pkg::inst_t inst_o,
    output logic              issue_valid_o
);

    core_pipe_pkg::issue_state_e state_q;
    core_pipe_pkg::issue_state_e state_d;
    rv_isa_pkg::inst_t           inst_q;
    logic                        issue_q;
    logic                        accept;

    // take a new word only when idle and the result side has drained
    assign accept = (state_q == core_pipe_pkg::ISS_IDLE) && inst_req_i && !wb_busy_i;

    always_comb begin
        state_d = state_q;
        case (state_q)
            core_pipe_pkg::ISS_IDLE: begin
                if (accept) begin
                    state_d = core_pipe_pkg::ISS_ACKED;
                end
            end
            // hold ack until the source lets go of req
            core_pipe_pkg::ISS_ACKED: begin
                if (!inst_req_i) begin
                    state_d = core_pipe_pkg::ISS_WAIT_WB;
                end
            end
            core_pipe_pkg::ISS_WAIT_WB: begin
                if (!wb_busy_i) begin
                    state_d = core_pipe_pkg::ISS_IDLE;
                end
            end
            default: state_d = core_pipe_pkg::ISS_IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst_n) begin
            state_q <= core_pipe_pkg::ISS_IDLE;
            issue_q <= 1'b0;
        end else begin
            state_q <= state_d;
            issue_q <= accept;
        end
    end

    // instruction latch
    always_ff @(posedge clk) begin
        if (accept) begin
            inst_q <= inst_i;
        end
    end

    assign inst_ack_o    = (state_q == core_pipe_pkg::ISS_ACKED);
    assign inst_o        = inst_q;
    assign issue_valid_o = issue_q;

endmodule

//--- inst_decoder.sv
`timescale 1ns/1ps

module inst_decoder (
    input  rv_isa_pkg::inst_t      inst_i,
    output rv_isa_pkg::reg_idx_t   rs1_idx_o,
    output rv_isa_pkg::reg_idx_t   rs2_idx_o,
    input  rv_isa_pkg::xlen_t      rs1_data_i,
    input  rv_isa_pkg::xlen_t      rs2_data_i,
    output core_pipe_pkg::dec_ex_t dec_o
);

    rv_isa_pkg::opcode_e opcode;
    logic [2:0]          funct3;
    logic [6:0]          funct7;
    logic                alt;
    rv_isa_pkg::xlen_t   imm_i;
    rv_isa_pkg::xlen_t   imm_u;
    rv_isa_pkg::alu_op_e alu_op;
    logic                legal;

    assign opcode    = rv_isa_pkg::opcode_e'(inst_i[6:0]);
    assign funct3    = inst_i[14:12];
    assign funct7    = inst_i[31:25];
    assign rs1_idx_o = inst_i[19:15];
    assign rs2_idx_o = inst_i[24:20];

    // sign extended I and U immediates
    assign imm_i = rv_isa_pkg::xlen_t'($signed(inst_i[31:20]));
    assign imm_u = rv_isa_pkg::xlen_t'($signed({inst_i[31:12], 12'b0}));

    // inst[30] picks sub/sra; op-imm has no subi so only funct3 101 counts there
    assign alt = inst_i[30] && ((opcode == rv_isa_pkg::OP) || (funct3 == 3'b101));

    always_comb begin
        case (funct3)
            3'b000:  alu_op = alt ? rv_isa_pkg::SUB : rv_isa_pkg::ADD;
            3'b001:  alu_op = rv_isa_pkg::SLL;
            3'b010:  alu_op = rv_isa_pkg::SLT;
            3'b011:  alu_op = rv_isa_pkg::SLTU;
            3'b100:  alu_op = rv_isa_pkg::XOR;
            3'b101:  alu_op = alt ? rv_isa_pkg::SRA : rv_isa_pkg::SRL;
            3'b110:  alu_op = rv_isa_pkg::OR;
            default: alu_op = rv_isa_pkg::AND;
        endcase
    end

    // legality per opcode
    always_comb begin
        case (opcode)
            rv_isa_pkg::OP: begin
                legal = (funct7 == 7'b0000000) ||
                        ((funct7 == 7'b0100000) && ((funct3 == 3'b000) || (funct3 == 3'b101)));
            end
            rv_isa_pkg::OP_IMM: begin
                // 6-bit shamt leaves inst[31:26] for the shift kind
                if (funct3 == 3'b001) begin
                    legal = (inst_i[31:26] == 6'b000000);
                end else if (funct3 == 3'b101) begin
                    legal = (inst_i[31:26] == 6'b000000) || (inst_i[31:26] == 6'b010000);
                end else begin
                    legal = 1'b1;
                end
            end
            rv_isa_pkg::LUI: legal = 1'b1;
            default:         legal = 1'b0;
        endcase
    end

    //**********************************************************************
    // operand forming
    //**********************************************************************

    always_comb begin
        dec_o.alu_op  = (opcode == rv_isa_pkg::LUI) ? rv_isa_pkg::PASS_B : alu_op;
        dec_o.op_a    = (opcode == rv_isa_pkg::LUI) ? '0 : rs1_data_i;
        dec_o.op_b    = (opcode == rv_isa_pkg::OP)  ? rs2_data_i :
                        (opcode == rv_isa_pkg::LUI) ? imm_u : imm_i;
        dec_o.rd      = inst_i[11:7];
        dec_o.wr_en   = legal;
        dec_o.illegal = !legal;
    end

endmodule

//--- alu_execute.sv
`timescale 1ns/1ps

module alu_execute (
    input  core_pipe_pkg::dec_ex_t dec_i,
    output core_pipe_pkg::ex_wb_t  ex_o
);

    rv_isa_pkg::xlen_t a;
    rv_isa_pkg::xlen_t b;
    logic [5:0]        shamt;
    logic              lt_s;
    logic              lt_u;
    rv_isa_pkg::xlen_t res;

    assign a     = dec_i.op_a;
    assign b     = dec_i.op_b;
    // rv64 shifts only look at six bits
    assign shamt = b[5:0];

    // compares
    assign lt_s = $signed(a) < $signed(b);
    assign lt_u = a < b;

    always_comb begin
        case (dec_i.alu_op)
            rv_isa_pkg::ADD:    res = a + b;
            rv_isa_pkg::SUB:    res = a - b;
            rv_isa_pkg::SLL:    res = a << shamt;
            rv_isa_pkg::SLT:    res = rv_isa_pkg::xlen_t'(lt_s);
            rv_isa_pkg::SLTU:   res = rv_isa_pkg::xlen_t'(lt_u);
            rv_isa_pkg::XOR:    res = a ^ b;
            rv_isa_pkg::SRL:    res = a >> shamt;
            rv_isa_pkg::SRA:    res = $signed(a) >>> shamt;
            rv_isa_pkg::OR:     res = a | b;
            rv_isa_pkg::AND:    res = a & b;
            rv_isa_pkg::PASS_B: res = b;
            default:            res = '0;
        endcase
    end

    //**********************************************************************
    // hand off to writeback
    //**********************************************************************

    always_comb begin
        ex_o.rd      = dec_i.rd;
        ex_o.wr_en   = dec_i.wr_en;
        ex_o.illegal = dec_i.illegal;
        // illegal ops always report zero
        ex_o.value   = dec_i.illegal ? '0 : res;
    end

endmodule

//--- reg_writeback.sv
`timescale 1ns/1ps
`include "core_cfg.svh"

module reg_writeback (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   issue_valid_i,
    input  core_pipe_pkg::ex_wb_t  ex_i,
    input  rv_isa_pkg::reg_idx_t   rs1_idx_i,
    input  rv_isa_pkg::reg_idx_t   rs2_idx_i,
    output rv_isa_pkg::xlen_t      rs1_data_o,
    output rv_isa_pkg::xlen_t      rs2_data_o,
    output logic                   res_req_o,
    output core_pipe_pkg::result_t res_o,
    input  logic                   res_ack_i,
    output logic                   wb_busy_o
);

    rv_isa_pkg::xlen_t         regs_q [`CORE_NUM_REGS];
    core_pipe_pkg::result_t    res_q;
    core_pipe_pkg::wb_state_e  state_q;
    logic                      wr_fire;

    // x0 is hardwired
    assign rs1_data_o = (rs1_idx_i == '0) ? '0 : regs_q[rs1_idx_i];
    assign rs2_data_o = (rs2_idx_i == '0) ? '0 : regs_q[rs2_idx_i];

    assign wr_fire = issue_valid_i && ex_i.wr_en && (ex_i.rd != '0);

    always_ff @(posedge clk) begin
        if (rst_n) begin
            for (int i = 0; i < `CORE_NUM_REGS; i++) begin
                regs_q[i] <= '0;
            end
        end else if (wr_fire) begin
            regs_q[ex_i.rd] <= ex_i.value;
        end
    end

    // result stays stable for the whole output exchange
    always_ff @(posedge clk) begin
        if (issue_valid_i) begin
            res_q.rd      <= ex_i.rd;
            res_q.value   <= ex_i.value;
            res_q.illegal <= ex_i.illegal;
        end
    end

    //**********************************************************************
    // output four-phase handshake
    //**********************************************************************

    always_ff @(posedge clk) begin
        if (rst_n) begin
            state_q <= core_pipe_pkg::WB_IDLE;
        end else begin
            case (state_q)
                core_pipe_pkg::WB_IDLE: begin
                    if (issue_valid_i) begin
                        state_q <= core_pipe_pkg::WB_REQ;
                    end
                end
                core_pipe_pkg::WB_REQ: begin
                    if (res_ack_i) begin
                        state_q <= core_pipe_pkg::WB_DROP;
                    end
                end
                // wait for sink to drop ack
                core_pipe_pkg::WB_DROP: begin
                    if (!res_ack_i) begin
                        state_q <= core_pipe_pkg::WB_IDLE;
                    end
                end
                default: state_q <= core_pipe_pkg::WB_IDLE;
            endcase
        end
    end

    assign res_req_o = (state_q == core_pipe_pkg::WB_REQ);
    assign res_o     = res_q;
    assign wb_busy_o = issue_valid_i || (state_q != core_pipe_pkg::WB_IDLE);

endmodule

//--- rv_mini_core.sv
`timescale 1ns/1ps

module rv_mini_core (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   inst_req_i,
    input  rv_isa_pkg::inst_t      inst_i,
    output logic                   inst_ack_o,
    output logic                   res_req_o,
    output core_pipe_pkg::result_t res_o,
    input  logic                   res_ack_i
);

    //**********************************************************************
    // stage wires
    //**********************************************************************

    rv_isa_pkg::inst_t      inst_iss_dec;
    logic                   issue_valid;
    rv_isa_pkg::reg_idx_t   rs1_idx;
    rv_isa_pkg::reg_idx_t   rs2_idx;
    rv_isa_pkg::xlen_t      rs1_data;
    rv_isa_pkg::xlen_t      rs2_data;
    core_pipe_pkg::dec_ex_t dec_ex;
    core_pipe_pkg::ex_wb_t  ex_wb;
    logic                   wb_busy;

    inst_issue u_inst_issue (
        .clk           (clk         ),
        .rst_n         (rst_n       ),
        .inst_req_i    (inst_req_i  ),
        .inst_i        (inst_i      ),
        .wb_busy_i     (wb_busy     ),
        .inst_ack_o    (inst_ack_o  ),
        .inst_o        (inst_iss_dec),
        .issue_valid_o (issue_valid )
    );

    // decode and execute are purely combinational
    inst_decoder u_inst_decoder (
        .inst_i     (inst_iss_dec),
        .rs1_idx_o  (rs1_idx     ),
        .rs2_idx_o  (rs2_idx     ),
        .rs1_data_i (rs1_data    ),
        .rs2_data_i (rs2_data    ),
        .dec_o      (dec_ex      )
    );

    alu_execute u_alu_execute (
        .dec_i (dec_ex),
        .ex_o  (ex_wb )
    );

    reg_writeback u_reg_writeback (
        .clk           (clk        ),
        .rst_n         (rst_n      ),
        .issue_valid_i (issue_valid),
        .ex_i          (ex_wb      ),
        .rs1_idx_i     (rs1_idx    ),
        .rs2_idx_i     (rs2_idx    ),
        .rs1_data_o    (rs1_data   ),
        .rs2_data_o    (rs2_data   ),
        .res_req_o     (res_req_o  ),
        .res_o         (res_o      ),
        .res_ack_i     (res_ack_i  ),
        .wb_busy_o     (wb_busy    )
    );

endmodule

//--- tb_rv_mini_core.sv
`timescale 1ns/1ps
`include "core_cfg.svh"

module tb_rv_mini_core;

    localparam int WAIT_LIMIT = 50;

    logic                   clk;
    logic                   rst_n;
    logic                   inst_req;
    rv_isa_pkg::inst_t      inst;
    logic                   inst_ack;
    logic                   res_req;
    core_pipe_pkg::result_t res;
    logic                   res_ack;

    // reference state and bookkeeping
    rv_isa_pkg::xlen_t      ref_regs [`CORE_NUM_REGS];
    core_pipe_pkg::result_t exp_q [$];
    core_pipe_pkg::result_t got_q [$];
    logic [63:0]            rng_state;
    int                     err_count;
    int                     fail_count;
    int                     sent_count;
    int                     checked_count;

    rv_mini_core dut_i (
        .clk        (clk     ),
        .rst_n      (rst_n   ),
        .inst_req_i (inst_req),
        .inst_i     (inst    ),
        .inst_ack_o (inst_ack),
        .res_req_o  (res_req ),
        .res_o      (res    ),
        .res_ack_i  (res_ack )
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    //**********************************************************************
    // helpers
    //**********************************************************************

    function automatic logic [63:0] next_rand();
        rng_state = rng_state ^ (rng_state << 13);
        rng_state = rng_state ^ (rng_state >> 7);
        rng_state = rng_state ^ (rng_state << 17);
        return rng_state;
    endfunction

    function automatic rv_isa_pkg::inst_t enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                                input logic [4:0] rs1, input logic [2:0] f3,
                                                input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, 7'h33};
    endfunction

    function automatic rv_isa_pkg::inst_t enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                                input logic [2:0] f3, input logic [4:0] rd);
        return {imm, rs1, f3, rd, 7'h13};
    endfunction

    function automatic rv_isa_pkg::inst_t enc_lui(input logic [19:0] imm, input logic [4:0] rd);
        return {imm, rd, 7'h37};
    endfunction

    // random legal OP, OP-IMM or LUI
    function automatic rv_isa_pkg::inst_t rand_inst();
        logic [63:0]       r;
        logic [2:0]        f3;
        logic [6:0]        f7;
        logic [11:0]       imm;
        rv_isa_pkg::inst_t ins;
        r  = next_rand();
        f3 = r[10:8];
        if (r[2:0] < 3'd4) begin
            f7  = (r[11] && (f3 == 3'b000 || f3 == 3'b101)) ? 7'h20 : 7'h00;
            ins = enc_r(f7, r[16:12], r[21:17], f3, r[26:22]);
        end else if (r[2:0] == 3'd7) begin
            ins = enc_lui(r[46:27], r[26:22]);
        end else begin
            imm = r[43:32];
            if (f3 == 3'b001) begin
                imm = {6'h00, r[37:32]};
            end else if (f3 == 3'b101) begin
                imm = {(r[11] ? 6'h10 : 6'h00), r[37:32]};
            end
            ins = enc_i(imm, r[21:17], f3, r[26:22]);
        end
        return ins;
    endfunction

    //**********************************************************************
    // reference model
    //**********************************************************************

    function automatic core_pipe_pkg::result_t ref_exec(input rv_isa_pkg::inst_t ins);
        core_pipe_pkg::result_t r;
        logic [6:0]             opc;
        logic [2:0]             f3;
        logic [6:0]             f7;
        logic [63:0]            a;
        logic [63:0]            b;
        logic [5:0]             sh;
        logic [63:0]            val;
        logic                   legal;
        opc   = ins[6:0];
        f3    = ins[14:12];
        f7    = ins[31:25];
        a     = ref_regs[ins[19:15]];
        b     = 64'h0;
        val   = 64'h0;
        legal = 1'b0;
        if (opc == 7'h37) begin
            legal = 1'b1;
            val   = {{32{ins[31]}}, ins[31:12], 12'h000};
        end else if (opc == 7'h33 || opc == 7'h13) begin
            if (opc == 7'h33) begin
                b     = ref_regs[ins[24:20]];
                legal = (f7 == 7'h00) || (f7 == 7'h20 && (f3 == 3'b000 || f3 == 3'b101));
            end else begin
                b     = {{52{ins[31]}}, ins[31:20]};
                legal = 1'b1;
                if (f3 == 3'b001) begin
                    legal = (ins[31:26] == 6'h00);
                end else if (f3 == 3'b101) begin
                    legal = (ins[31:26] == 6'h00) || (ins[31:26] == 6'h10);
                end
            end
            sh = b[5:0];
            case (f3)
                3'b000:  val = (opc == 7'h33 && ins[30]) ? a - b : a + b;
                3'b001:  val = a << sh;
                3'b010:  val = ($signed(a) < $signed(b)) ? 64'd1 : 64'd0;
                3'b011:  val = (a < b) ? 64'd1 : 64'd0;
                3'b100:  val = a ^ b;
                3'b101: begin
                    if (ins[30]) begin
                        val = $signed(a) >>> sh;
                    end else begin
                        val = a >> sh;
                    end
                end
                3'b110:  val = a | b;
                default: val = a & b;
            endcase
        end
        if (!legal) begin
            val = 64'h0;
        end
        if (legal && ins[11:7] != 5'd0) begin
            ref_regs[ins[11:7]] = val;
        end
        r.rd      = ins[11:7];
        r.value   = val;
        r.illegal = !legal;
        return r;
    endfunction

    //**********************************************************************
    // checks and run control
    //**********************************************************************

    task automatic check_value(input string name, input logic [63:0] got, input logic [63:0] exp);
        if (got !== exp) begin
            $display("[ERROR] %s: got 0x%0h expected 0x%0h", name, got, exp);
            err_count++;
        end
    endtask

    task automatic finish_run();
        $display("%0d results checked, %0d value errors, %0d other failures",
                 checked_count, err_count, fail_count);
        if (err_count == 0 && fail_count == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    endtask

    task automatic wait_ack(input logic level);
        int cycles;
        cycles = 0;
        while (inst_ack !== level) begin
            @(negedge clk);
            cycles++;
            if (cycles > WAIT_LIMIT) begin
                $display("timed out waiting for inst_ack_o to become %0d", level);
                fail_count++;
                finish_run();
            end
        end
    endtask

    task automatic wait_res_req(input logic level);
        int cycles;
        cycles = 0;
        while (res_req !== level) begin
            @(negedge clk);
            cycles++;
            if (cycles > WAIT_LIMIT) begin
                $display("timed out waiting for res_req_o to become %0d", level);
                fail_count++;
                finish_run();
            end
        end
    endtask

    //**********************************************************************
    // handshake drivers
    //**********************************************************************

    task automatic start_req(input rv_isa_pkg::inst_t ins);
        @(negedge clk);
        exp_q.push_back(ref_exec(ins));
        sent_count++;
        inst     = ins;
        inst_req = 1'b1;
    endtask

    task automatic finish_req();
        wait_ack(1'b1);
        inst_req = 1'b0;
        wait_ack(1'b0);
    endtask

    // sink acks after 0 to 3 cycles
    task automatic collect_result();
        int delay;
        wait_res_req(1'b1);
        got_q.push_back(res);
        delay = int'(next_rand() & 64'h3);
        repeat (delay) @(negedge clk);
        res_ack = 1'b1;
        wait_res_req(1'b0);
        res_ack = 1'b0;
    endtask

    task automatic run_inst(input rv_isa_pkg::inst_t ins);
        start_req(ins);
        finish_req();
        collect_result();
    endtask

    // second request must stall while the first result is unacked
    task automatic check_back_pressure(input rv_isa_pkg::inst_t first,
                                       input rv_isa_pkg::inst_t second);
        start_req(first);
        finish_req();
        start_req(second);
        for (int i = 0; i < 12; i++) begin
            @(negedge clk);
            check_value("inst_ack_o", 64'(inst_ack), 64'h0);
            check_value("res_req_o", 64'(res_req), 64'h1);
        end
        collect_result();
        finish_req();
        collect_result();
    endtask

    initial begin : compare_proc
        core_pipe_pkg::result_t got;
        core_pipe_pkg::result_t exp;
        forever begin
            @(negedge clk);
            while (got_q.size() > 0) begin
                got = got_q.pop_front();
                if (exp_q.size() == 0) begin
                    $display("a result was reported with no instruction outstanding");
                    fail_count++;
                end else begin
                    exp = exp_q.pop_front();
                    check_value("res_o.rd", 64'(got.rd), 64'(exp.rd));
                    check_value("res_o.value", got.value, exp.value);
                    check_value("res_o.illegal", 64'(got.illegal), 64'(exp.illegal));
                    checked_count++;
                end
            end
        end
    end

    //**********************************************************************
    // stimulus
    //**********************************************************************

    initial begin : main_proc
        inst_req      = 1'b0;
        inst          = '0;
        res_ack       = 1'b0;
        rst_n         = 1'b1;
        rng_state     = 64'd63;
        err_count     = 0;
        fail_count    = 0;
        sent_count    = 0;
        checked_count = 0;
        for (int i = 0; i < `CORE_NUM_REGS; i++) begin
            ref_regs[i] = '0;
        end
        repeat (5) @(negedge clk);
        rst_n = 1'b0;
        @(negedge clk);
        check_value("inst_ack_o", 64'(inst_ack), 64'h0);
        check_value("res_req_o", 64'(res_req), 64'h0);

        // every register starts at zero
        for (int i = 1; i < `CORE_NUM_REGS; i++) begin
            run_inst(enc_r(7'h00, 5'(i), 5'd0, 3'b000, 5'(i)));
        end

        // constants from lui and addi
        run_inst(enc_lui(20'h12345, 5'd1));
        run_inst(enc_i(12'h678, 5'd1, 3'b000, 5'd1));
        run_inst(enc_lui(20'hfedcb, 5'd2));
        run_inst(enc_i(12'hfff, 5'd2, 3'b000, 5'd2));
        run_inst(enc_lui(20'h80000, 5'd3));
        run_inst(enc_i(12'h7ff, 5'd0, 3'b000, 5'd4));

        // signed and unsigned compares, shifts of negative values
        run_inst(enc_r(7'h00, 5'd1, 5'd3, 3'b010, 5'd5));
        run_inst(enc_r(7'h00, 5'd1, 5'd3, 3'b011, 5'd5));
        run_inst(enc_i(12'h000, 5'd3, 3'b010, 5'd6));
        run_inst(enc_i(12'hfff, 5'd3, 3'b011, 5'd6));
        run_inst(enc_i(12'h404, 5'd3, 3'b101, 5'd7));
        run_inst(enc_r(7'h20, 5'd4, 5'd2, 3'b101, 5'd8));
        run_inst(enc_r(7'h00, 5'd4, 5'd3, 3'b101, 5'd9));
        run_inst(enc_r(7'h00, 5'd4, 5'd1, 3'b001, 5'd10));
        run_inst(enc_r(7'h20, 5'd2, 5'd1, 3'b000, 5'd11));
        run_inst(enc_i(12'h020, 5'd1, 3'b001, 5'd12));

        for (int n = 0; n < 300; n++) begin
            run_inst(rand_inst());
        end

        // x0 reports its value but stays zero
        run_inst(enc_i(12'h005, 5'd1, 3'b000, 5'd0));
        run_inst(enc_r(7'h00, 5'd0, 5'd0, 3'b000, 5'd13));
        run_inst(enc_r(7'h00, 5'd1, 5'd0, 3'b000, 5'd14));

        // load, jal, mul, bad funct7 and bad slli, then read back x1 and x2
        run_inst({12'h000, 5'd2, 3'b011, 5'd1, 7'h03});
        run_inst({20'h00010, 5'd2, 7'h6f});
        run_inst(enc_r(7'h01, 5'd2, 5'd1, 3'b000, 5'd1));
        run_inst(enc_r(7'h20, 5'd2, 5'd1, 3'b100, 5'd2));
        run_inst(enc_i(12'h401, 5'd1, 3'b001, 5'd1));
        run_inst(enc_r(7'h00, 5'd0, 5'd1, 3'b000, 5'd15));
        run_inst(enc_r(7'h00, 5'd0, 5'd2, 3'b000, 5'd16));

        check_back_pressure(enc_i(12'h123, 5'd1, 3'b000, 5'd17),
                            enc_r(7'h00, 5'd17, 5'd1, 3'b000, 5'd18));

        // nothing repeated once the queue drains
        repeat (4) @(negedge clk);
        check_value("res_req_o", 64'(res_req), 64'h0);
        if (exp_q.size() != 0) begin
            $display("%0d expected results were never reported", exp_q.size());
            fail_count++;
        end
        check_value("results checked", 64'(checked_count), 64'(sent_count));
        finish_run();
    end

endmodule

//--- filelist.f
+incdir+.
rv_isa_pkg.sv
core_pipe_pkg.sv
inst_issue.sv
inst_decoder.sv
alu_execute.sv
reg_writeback.sv
rv_mini_core.sv
tb_rv_mini_core.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing
TOP       ?= tb_rv_mini_core
FILELIST  ?= filelist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
FAIL_MSG  := Simulation failed
PASS_MSG  := Simulation passed

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --timing -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR) -o V$(TOP)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
